// File: source/bus_pkg.sv
package bus_pkg;

   // ########################################
   // Memory bus field types
   // ########################################

   // One data word on any of the buses
   typedef logic [31:0] word_t;

   // Byte address, the low two bits pick a byte inside a word
   typedef logic [31:0] adr_t;

   // Byte lane enables, bit n covers bits 8n+7 to 8n of a word
   typedef logic [3:0]  sel_t;

endpackage

// File: source/soc_pkg.sv
package soc_pkg;

   // ########################################
   // Address map
   // ########################################

   // Region field at the top of the data address
   typedef logic [1:0] region_t;

   // Top bit of the region field
   localparam int c_region_msb = 31;

   // Shared word memory, 0x0000_0000 upwards
   localparam region_t c_region_mem   = 2'd0;

   // Machine timer, 0x8000_0000 upwards
   localparam region_t c_region_timer = 2'd2;

   // Any other region value goes out on the external bus

endpackage

// File: source/soc_arbiter.sv
`timescale 1ns/10ps

module soc_arbiter
   import bus_pkg::*;
(
   // Data side, already limited to the memory region
   input  adr_t  i_dbus_adr,
   input  word_t i_dbus_dat,
   input  sel_t  i_dbus_sel,
   input  logic  i_dbus_we,
   input  logic  i_dbus_cyc,
   output word_t o_dbus_rdt,

   // Instruction side
   input  adr_t  i_ibus_adr,
   input  logic  i_ibus_cyc,
   output word_t o_ibus_rdt,
   output logic  o_ibus_ack,

   // Shared memory port
   output adr_t  o_mem_adr,
   output word_t o_mem_dat,
   output sel_t  o_mem_sel,
   output logic  o_mem_we,
   output logic  o_mem_cyc,
   input  word_t i_mem_rdt,
   input  logic  i_mem_ack
);

   // Data side owns the port whenever it asks
   assign o_mem_adr = i_dbus_cyc ? i_dbus_adr : i_ibus_adr;
   assign o_mem_sel = i_dbus_cyc ? i_dbus_sel : '1;
   assign o_mem_dat = i_dbus_dat;                 // Fetches never write
   assign o_mem_we  = i_dbus_cyc & i_dbus_we;
   assign o_mem_cyc = i_dbus_cyc | i_ibus_cyc;

   assign o_dbus_rdt = i_mem_rdt;
   assign o_ibus_rdt = i_mem_rdt;

   // An ack seen while data cyc is up belongs to the data access
   assign o_ibus_ack = i_mem_ack & ~i_dbus_cyc;

endmodule

// File: source/soc_mux.sv
`timescale 1ns/10ps

module soc_mux
   import bus_pkg::*, soc_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_arst_n,

   // Data bus from the core
   input  adr_t  i_dbus_adr,
   input  word_t i_dbus_dat,
   input  sel_t  i_dbus_sel,
   input  logic  i_dbus_we,
   input  logic  i_dbus_cyc,
   output word_t o_int_rdt,
   output logic  o_int_ack,

   // Memory region
   output logic  o_mem_cyc,
   input  word_t i_mem_rdt,

   // Timer region
   output logic  o_timer_we,
   output logic  o_timer_cyc,
   input  word_t i_timer_rdt,

   // External region
   output adr_t  o_xbus_adr,
   output word_t o_xbus_dat,
   output sel_t  o_xbus_sel,
   output logic  o_xbus_we,
   output logic  o_xbus_cyc
);

   region_t region;
   logic    sel_mem;
   logic    sel_timer;
   logic    sel_int;
   logic    int_req;       // Internal access waiting for its ack
   logic    timer_q;       // Last acked access went to the timer
   word_t   timer_rdt_q;

   // ########################################
   // Region decode
   // ########################################

   assign region    = i_dbus_adr[c_region_msb -: $bits(region_t)];
   assign sel_mem   = (region == c_region_mem);
   assign sel_timer = (region == c_region_timer);
   assign sel_int   = sel_mem | sel_timer;

   assign o_mem_cyc   = i_dbus_cyc & sel_mem;
   assign o_timer_cyc = i_dbus_cyc & sel_timer;
   assign o_timer_we  = i_dbus_we;

   // Everything else goes out unchanged
   assign o_xbus_cyc = i_dbus_cyc & ~sel_int;
   assign o_xbus_adr = i_dbus_adr;
   assign o_xbus_dat = i_dbus_dat;
   assign o_xbus_sel = i_dbus_sel;
   assign o_xbus_we  = i_dbus_we;

   // ########################################
   // Internal acknowledge and read data
   // ########################################

   assign int_req = i_dbus_cyc & sel_int & ~o_int_ack;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_int_ack <= 1'b0;
         timer_q   <= 1'b0;
      end else begin
         o_int_ack <= int_req;
         if (int_req)
            timer_q <= sel_timer;
      end
   end

   // Counter value taken at the same edge as the RAM read
   always_ff @(posedge i_clk) begin
      if (int_req & sel_timer)
         timer_rdt_q <= i_timer_rdt;
   end

   assign o_int_rdt = timer_q ? timer_rdt_q : i_mem_rdt;

endmodule

// File: source/soc_ram.sv
`timescale 1ns/10ps

module soc_ram
   import bus_pkg::*;
#(
   parameter int p_mem_depth = 8192          // Bytes, power of two
)
(
   input  logic  i_clk,
   input  logic  i_arst_n,
   input  adr_t  i_adr,
   input  logic  i_cyc,
   input  logic  i_we,
   input  sel_t  i_sel,
   input  word_t i_dat,
   output word_t o_rdt,
   output logic  o_ack
);

   localparam int c_words   = p_mem_depth / 4;
   localparam int c_adr_msb = $clog2(p_mem_depth) - 1;

   word_t                      mem [0:c_words-1];
   logic  [c_adr_msb-2:0]      word_idx;

   assign word_idx = i_adr[c_adr_msb:2];

   // Byte lane writes and registered read
   always_ff @(posedge i_clk) begin
      if (i_cyc) begin
         if (i_we) begin
            for (int b = 0; b < $bits(sel_t); b++) begin
               if (i_sel[b])
                  mem[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
            end
         end
         o_rdt <= mem[word_idx];
      end
   end

   // One cycle pulse, a held cyc acks every other cycle
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_ack <= 1'b0;
      else
         o_ack <= i_cyc & ~o_ack;
   end

endmodule

// File: source/soc_timer.sv
`timescale 1ns/10ps

module soc_timer
   import bus_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_arst_n,
   input  logic  i_cyc,
   input  logic  i_we,
   input  word_t i_dat,
   output word_t o_rdt,
   output logic  o_irq
);

   word_t mtime;
   word_t mtimecmp;
   word_t time_diff;

   // Wrap-safe compare, the sign of the difference decides
   assign time_diff = mtime - mtimecmp;
   assign o_rdt     = mtime;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime    <= '0;
         mtimecmp <= 32'h8000_0000;   // Half a wrap away
         o_irq    <= 1'b0;
      end else begin
         mtime <= mtime + 32'd1;
         if (i_cyc && i_we)
            mtimecmp <= i_dat;
         o_irq <= ~time_diff[$bits(word_t)-1];
      end
   end

endmodule

// File: source/soc_top.sv
`timescale 1ns/10ps

module soc_top
   import bus_pkg::*;
#(
   parameter int p_mem_depth  = 8192,
   parameter bit p_with_timer = 1
)
(
   input  logic  i_clk,
   input  logic  i_arst_n,

   // Instruction bus from the core
   input  adr_t  i_ibus_adr,
   input  logic  i_ibus_cyc,
   output word_t o_ibus_rdt,
   output logic  o_ibus_ack,

   // Data bus from the core
   input  adr_t  i_dbus_adr,
   input  word_t i_dbus_dat,
   input  sel_t  i_dbus_sel,
   input  logic  i_dbus_we,
   input  logic  i_dbus_cyc,
   output word_t o_dbus_rdt,
   output logic  o_dbus_ack,

   // External bus
   output adr_t  o_xbus_adr,
   output word_t o_xbus_dat,
   output sel_t  o_xbus_sel,
   output logic  o_xbus_we,
   output logic  o_xbus_cyc,
   input  word_t i_xbus_rdt,
   input  logic  i_xbus_ack,

   output logic  o_timer_irq
);

   // Internal data answer
   word_t int_rdt;
   logic  int_ack;

   // Data side of the memory
   logic  dmem_cyc;
   word_t dmem_rdt;

   // Shared memory port
   adr_t  mem_adr;
   word_t mem_dat;
   sel_t  mem_sel;
   logic  mem_we;
   logic  mem_cyc;
   word_t mem_rdt;
   logic  mem_ack;

   logic  timer_we;
   logic  timer_cyc;
   word_t timer_rdt;

   // ########################################
   // Bus fabric
   // ########################################

   soc_mux soc_mux_i (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_dbus_adr  (i_dbus_adr),
      .i_dbus_dat  (i_dbus_dat),
      .i_dbus_sel  (i_dbus_sel),
      .i_dbus_we   (i_dbus_we),
      .i_dbus_cyc  (i_dbus_cyc),
      .o_int_rdt   (int_rdt),
      .o_int_ack   (int_ack),
      .o_mem_cyc   (dmem_cyc),
      .i_mem_rdt   (dmem_rdt),
      .o_timer_we  (timer_we),
      .o_timer_cyc (timer_cyc),
      .i_timer_rdt (timer_rdt),
      .o_xbus_adr  (o_xbus_adr),
      .o_xbus_dat  (o_xbus_dat),
      .o_xbus_sel  (o_xbus_sel),
      .o_xbus_we   (o_xbus_we),
      .o_xbus_cyc  (o_xbus_cyc)
   );

   // Address, data and selects come straight off the data bus
   soc_arbiter soc_arbiter_i (
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (dmem_cyc),
      .o_dbus_rdt (dmem_rdt),
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .o_mem_adr  (mem_adr),
      .o_mem_dat  (mem_dat),
      .o_mem_sel  (mem_sel),
      .o_mem_we   (mem_we),
      .o_mem_cyc  (mem_cyc),
      .i_mem_rdt  (mem_rdt),
      .i_mem_ack  (mem_ack)
   );

   // ########################################
   // Slaves
   // ########################################

   soc_ram #(
      .p_mem_depth (p_mem_depth)
   ) soc_ram_i (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_adr    (mem_adr),
      .i_cyc    (mem_cyc),
      .i_we     (mem_we),
      .i_sel    (mem_sel),
      .i_dat    (mem_dat),
      .o_rdt    (mem_rdt),
      .o_ack    (mem_ack)
   );

   generate
      if (p_with_timer) begin : g_timer
         soc_timer soc_timer_i (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_cyc    (timer_cyc),
            .i_we     (timer_we),
            .i_dat    (i_dbus_dat),
            .o_rdt    (timer_rdt),
            .o_irq    (o_timer_irq)
         );
      end else begin : g_no_timer
         assign timer_rdt   = '0;     // Timer region reads as zero
         assign o_timer_irq = 1'b0;
      end
   endgenerate

   // External answer wins the read data
   assign o_dbus_rdt = i_xbus_ack ? i_xbus_rdt : int_rdt;
   assign o_dbus_ack = i_xbus_ack | int_ack;

endmodule

// File: test/soc_tb.sv
`timescale 1ns/10ps

module soc_tb
   import bus_pkg::*, soc_pkg::*;
();

   localparam int   c_mem_depth   = 8192;
   localparam int   c_idx_msb     = $clog2(c_mem_depth) - 1;
   localparam int   c_ack_limit   = 20;
   localparam int   c_cycle_limit = 4000;
   localparam int   c_access_gap  = 2;     // Idle cycle before cyc plus the ack cycle
   localparam adr_t c_timer_adr   = 32'h8000_0000;

   logic  i_clk = 1'b0;
   logic  i_arst_n;
   adr_t  i_ibus_adr;
   logic  i_ibus_cyc, o_ibus_ack;
   word_t o_ibus_rdt;
   adr_t  i_dbus_adr;
   word_t i_dbus_dat, o_dbus_rdt;
   sel_t  i_dbus_sel;
   logic  i_dbus_we, i_dbus_cyc, o_dbus_ack;
   adr_t  o_xbus_adr;
   word_t o_xbus_dat, i_xbus_rdt;
   sel_t  o_xbus_sel;
   logic  o_xbus_we, o_xbus_cyc, i_xbus_ack;
   logic  o_timer_irq;

   integer seed = 32'hcd07_c611;
   int     errors = 0;
   int     checks = 0;
   int     cycle_cnt = 0;
   word_t  model_mem [0:c_mem_depth/4-1];
   adr_t   adrs [30];

   always #50 i_clk = ~i_clk;

   soc_top #(
      .p_mem_depth  (c_mem_depth),
      .p_with_timer (1'b1)
   ) soc_top_i (.*);

   // ########################################
   // Helpers
   // ########################################

   function automatic word_t rand_word();
      return $random(seed);
   endfunction

   function automatic logic internal_region(input adr_t adr);
      return (adr[c_region_msb -: 2] == c_region_mem) ||
             (adr[c_region_msb -: 2] == c_region_timer);
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t dat, input sel_t sel);
      word_t res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            res[8*b +: 8] = dat[8*b +: 8];
      end
      return res;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      assert (act === exp)
      else begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_protocol(input string what);
      errors++;
      $display("Protocol error in cycle %0d: %s", cycle_cnt, what);
   endtask

   // ########################################
   // Bus master tasks
   // ########################################

   // Also plays the external slave when the address leaves the internal regions
   task automatic data_access(input adr_t adr, input logic we, input word_t dat,
                              input sel_t sel, output word_t rdt);
      logic  ext;
      logic  got;
      int    delay;
      int    lat;
      word_t xdat;
      ext   = !internal_region(adr);
      delay = {$random(seed)} % 6;
      xdat  = rand_word();
      lat   = 0;
      got   = 1'b0;
      @(negedge i_clk);
      i_dbus_adr = adr;
      i_dbus_we  = we;
      i_dbus_dat = dat;
      i_dbus_sel = sel;
      i_dbus_cyc = 1'b1;
      while (!got && lat < c_ack_limit) begin
         if (ext && lat == delay) begin
            i_xbus_rdt = xdat;
            i_xbus_ack = 1'b1;
         end
         @(negedge i_clk);
         lat++;
         got = o_dbus_ack;            // Sampled before anything changes
         rdt = o_dbus_rdt;
         i_xbus_ack = 1'b0;
         if (lat == 1) begin
            check_word("xbus cyc", {31'b0, ext}, {31'b0, o_xbus_cyc});
            if (ext) begin
               check_word("xbus adr", adr, o_xbus_adr);
               check_word("xbus dat", dat, o_xbus_dat);
               check_word("xbus we sel", {27'b0, we, sel}, {27'b0, o_xbus_we, o_xbus_sel});
            end
         end
      end
      i_dbus_cyc = 1'b0;
      if (!got)
         report_protocol($sformatf("no data ack within %0d cycles for %h", c_ack_limit, adr));
      else if (ext) begin
         check_word("xbus ack latency", delay + 1, lat);
         if (!we)
            check_word("xbus read", xdat, rdt);
      end else
         check_word("data ack latency", 1, lat);
   endtask

   task automatic fetch(input adr_t adr, output word_t rdt);
      logic got;
      int   lat;
      got = 1'b0;
      lat = 0;
      @(negedge i_clk);
      i_ibus_adr = adr;
      i_ibus_cyc = 1'b1;
      while (!got && lat < c_ack_limit) begin
         @(negedge i_clk);
         lat++;
         got = o_ibus_ack;
         rdt = o_ibus_rdt;
      end
      i_ibus_cyc = 1'b0;
      if (!got)
         report_protocol($sformatf("no fetch ack within %0d cycles for %h", c_ack_limit, adr));
      else
         check_word("fetch ack latency", 1, lat);
   endtask

   // Data read and fetch raised in the same cycle
   task automatic fetch_behind_data(input adr_t dadr, input adr_t iadr);
      logic dack;
      logic iack;
      logic dgot;
      logic igot;
      int   n;
      dgot = 1'b0;
      igot = 1'b0;
      n    = 0;
      @(negedge i_clk);
      i_dbus_adr = dadr;
      i_dbus_we  = 1'b0;
      i_dbus_sel = 4'hf;
      i_dbus_cyc = 1'b1;
      i_ibus_adr = iadr;
      i_ibus_cyc = 1'b1;
      while (!igot && n < c_ack_limit) begin
         @(negedge i_clk);
         n++;
         dack = o_dbus_ack;
         iack = o_ibus_ack;
         if (iack) begin
            igot = 1'b1;
            check_word("fetch after data", 1, {31'b0, dgot & ~i_dbus_cyc});
            check_word("fetch behind data", model_mem[iadr[c_idx_msb:2]], o_ibus_rdt);
            i_ibus_cyc = 1'b0;
         end
         if (dack && !dgot) begin
            dgot = 1'b1;
            check_word("data acked first", 0, {31'b0, igot});
            check_word("data before fetch", model_mem[dadr[c_idx_msb:2]], o_dbus_rdt);
            i_dbus_cyc = 1'b0;
         end
      end
      i_dbus_cyc = 1'b0;
      i_ibus_cyc = 1'b0;
      if (!igot)
         report_protocol("fetch never acked after the data access");
   endtask

   // ########################################
   // Protocol assertions
   // ########################################

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $rose(i_dbus_cyc) && internal_region(i_dbus_adr) |=> o_dbus_ack)
   else report_protocol("internal data ack did not follow cyc by one cycle");

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_xbus_cyc |-> !internal_region(i_dbus_adr))
   else report_protocol("external bus raised for an internal address");

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_dbus_ack |=> !o_dbus_ack)
   else report_protocol("data ack lasted more than one cycle");

   initial begin : watchdog
      while (cycle_cnt < c_cycle_limit) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", c_cycle_limit);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin : main
      word_t rdt;
      word_t dat;
      word_t t0;
      word_t t1;
      sel_t  sel;
      adr_t  adr;
      int    wait_n;
      int    n;
      i_arst_n   = 1'b0;
      i_ibus_adr = '0;
      i_ibus_cyc = 1'b0;
      i_dbus_adr = '0;
      i_dbus_dat = '0;
      i_dbus_sel = '0;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b0;
      i_xbus_rdt = '0;
      i_xbus_ack = 1'b0;
      repeat (16) @(negedge i_clk);
      i_arst_n = 1'b1;
      @(negedge i_clk);
      check_word("reset acks", 0, {29'b0, o_dbus_ack, o_ibus_ack, o_xbus_cyc});
      check_word("reset irq", 0, {31'b0, o_timer_irq});

      // Full words first so every model byte is known
      for (int i = 0; i < 30; i++) begin
         dat     = rand_word();
         adrs[i] = dat & (c_mem_depth - 4);
         dat     = rand_word();
         data_access(adrs[i], 1'b1, dat, 4'hf, rdt);
         model_mem[adrs[i][c_idx_msb:2]] = dat;
      end
      for (int i = 0; i < 30; i++) begin
         dat = rand_word();
         sel = dat[3:0];
         dat = rand_word();
         data_access(adrs[i], 1'b1, dat, sel, rdt);
         model_mem[adrs[i][c_idx_msb:2]] = merge_bytes(model_mem[adrs[i][c_idx_msb:2]], dat, sel);
      end
      for (int i = 0; i < 30; i++) begin
         data_access(adrs[i], 1'b0, '0, 4'hf, rdt);
         check_word("memory read", model_mem[adrs[i][c_idx_msb:2]], rdt);
      end

      for (int i = 0; i < 30; i++) begin
         fetch(adrs[i], rdt);
         check_word("fetch", model_mem[adrs[i][c_idx_msb:2]], rdt);
      end
      for (int i = 0; i < 4; i++)
         fetch_behind_data(adrs[i], adrs[29-i]);

      for (int i = 0; i < 12; i++) begin
         dat = rand_word();
         adr = rand_word();
         adr[c_region_msb -: 2] = dat[0] ? 2'b11 : 2'b01;   // External regions only
         data_access(adr, dat[1], rand_word(), dat[7:4], rdt);
      end

      data_access(c_timer_adr, 1'b0, '0, 4'hf, t0);
      wait_n = 10 + ({$random(seed)} % 10);
      repeat (wait_n) @(negedge i_clk);
      data_access(c_timer_adr, 1'b0, '0, 4'hf, t1);
      check_word("timer delta", wait_n + c_access_gap, t1 - t0);

      data_access(c_timer_adr, 1'b0, '0, 4'hf, t0);
      data_access(c_timer_adr, 1'b1, t0 + 40, 4'hf, rdt);
      for (n = 0; n < 30; n++) begin
         @(negedge i_clk);
         check_word("irq before compare", 0, {31'b0, o_timer_irq});
      end
      n = 0;
      while (!o_timer_irq && n < 50) begin
         @(negedge i_clk);
         n++;
      end
      check_word("irq after compare", 1, {31'b0, o_timer_irq});

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: tb.f
source/bus_pkg.sv
source/soc_pkg.sv
source/soc_arbiter.sv
source/soc_mux.sv
source/soc_ram.sv
source/soc_timer.sv
source/soc_top.sv
test/soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

PASS_MSG := RESULT: PASS
SOURCES  := $(wildcard source/*.sv) $(wildcard test/*.sv)
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run and look for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulation status alone is not trusted, the pass line decides
test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
